// File: compile.f
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/op_decode.sv
rtl/psw_cex_unit.sv
rtl/cycle_sequencer.sv
rtl/control_unit.sv
testbench/control_unit_asserts.sv
testbench/tb_control_unit.sv

// File: rtl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import ctrl_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              cpucycle_rst,
	input  wire logic [6:0]        op,
	input  wire logic [3:0]        cond,
	input  wire logic [2:0]        true_cnt,
	input  wire logic [2:0]        false_cnt,
	input  wire logic [4:0]        pswb,
	input  wire logic [2:0]        dst,
	input  wire logic [2:0]        srccon,
	input  wire logic              wb,
	input  wire logic              rc,
	input  wire logic [DATA_W-1:0] pc,
	input  wire logic [DATA_W-1:0] brkpnt,
	input  wire logic [DATA_W-1:0] psw_in,
	output logic                   mar_load,
	output logic                   id_enable,
	output logic                   alu_enable,
	output logic                   sxt_enable,
	output logic                   s_bus_ctrl,
	output logic                   psw_update,
	output logic [5:0]             alu_op,
	output logic [RNUM_W-1:0]      alu_rnum_dst,
	output logic [RNUM_W-1:0]      alu_rnum_src,
	output logic [RNUM_W-1:0]      dbus_rnum_dst,
	output logic [RNUM_W-1:0]      dbus_rnum_src,
	output bus_src_e               data_src,
	output bus_dst_e               data_dst,
	output logic                   data_wb,
	output logic                   data_wr,
	output logic [DATA_W-1:0]      psw_out
);

	instr_class_e instr_class;
	logic         branch_taken;
	logic         cex_true;
	logic         instr_run;	// Not skipped by CEX
	logic         halted;	// At breakpoint
	logic         decode_strobe;
	logic         exec_strobe;

	op_decode i_op_decode (	// Conditions see the registered PSW
		.op           (op),
		.cond         (cond),
		.psw          (psw_out),
		.instr_class  (instr_class),
		.branch_taken (branch_taken),
		.cex_true     (cex_true)
	);

	psw_cex_unit i_psw_cex_unit (
		.clock         (clock),
		.cpucycle_rst  (cpucycle_rst),
		.psw_in        (psw_in),
		.pc            (pc),
		.brkpnt        (brkpnt),
		.instr_class   (instr_class),
		.pswb          (pswb),
		.cex_true      (cex_true),
		.true_cnt      (true_cnt),
		.false_cnt     (false_cnt),
		.decode_strobe (decode_strobe),
		.exec_strobe   (exec_strobe),
		.psw_out       (psw_out),
		.instr_run     (instr_run),
		.halted        (halted)
	);

	cycle_sequencer i_cycle_sequencer (
		.clock         (clock),
		.cpucycle_rst  (cpucycle_rst),
		.halted        (halted),
		.instr_run     (instr_run),
		.instr_class   (instr_class),
		.branch_taken  (branch_taken),
		.op            (op),
		.dst           (dst),
		.srccon        (srccon),
		.wb            (wb),
		.rc            (rc),
		.mar_load      (mar_load),
		.id_enable     (id_enable),
		.alu_enable    (alu_enable),
		.sxt_enable    (sxt_enable),
		.s_bus_ctrl    (s_bus_ctrl),
		.psw_update    (psw_update),
		.alu_op        (alu_op),
		.alu_rnum_dst  (alu_rnum_dst),
		.alu_rnum_src  (alu_rnum_src),
		.dbus_rnum_dst (dbus_rnum_dst),
		.dbus_rnum_src (dbus_rnum_src),
		.data_src      (data_src),
		.data_dst      (data_dst),
		.data_wb       (data_wb),
		.data_wr       (data_wr),
		.decode_strobe (decode_strobe),
		.exec_strobe   (exec_strobe)
	);

endmodule

`default_nettype wire

// File: rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// Five cycles per instruction
	typedef enum logic [2:0]
	{
		FETCH,		// PC to MAR
		PC_INC,		// PC plus 2
		IR_LOAD,	// MDR to IR
		DECODE,		// Decoder enable, CEX count
		EXECUTE		// Instruction controls
	} cycle_e;

	// Data-bus source select
	typedef enum logic [1:0]
	{
		MDR,
		REGFILE,
		IR,
		ALU
	} bus_src_e;

	// Data-bus destination select
	typedef enum logic [1:0]
	{
		MDR_DST,
		REG_DST,
		IR_DST
	} bus_dst_e;

	// Opcode class from the decoder
	typedef enum logic [2:0]
	{
		CLS_NONE,	// Unsupported opcode, no controls
		CLS_BRANCH,
		CLS_ALU,
		CLS_SHIFT,
		CLS_MOV,
		CLS_SETCC,
		CLS_CLRCC,
		CLS_CEX
	} instr_class_e;

	localparam int DATA_W = 16;	// Machine word
	localparam int RNUM_W = 5;	// Register number incl. constants

	localparam logic [RNUM_W-1:0] REG_PC     = 5'd7;
	localparam logic [RNUM_W-1:0] REG_CONST2 = 5'd10;	// Constant 2 for PC increment

	localparam logic [DATA_W-1:0] PSW_RESET = 16'h60e0;

endpackage

`default_nettype wire

// File: rtl/cycle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer import isa_pkg::*, ctrl_pkg::*;
(
	input  wire logic          clock,
	input  wire logic          cpucycle_rst,
	input  wire logic          halted,
	input  wire logic          instr_run,
	input  wire instr_class_e  instr_class,
	input  wire logic          branch_taken,
	input  wire logic [6:0]    op,
	input  wire logic [2:0]    dst,
	input  wire logic [2:0]    srccon,
	input  wire logic          wb,
	input  wire logic          rc,
	output logic               mar_load,
	output logic               id_enable,
	output logic               alu_enable,
	output logic               sxt_enable,
	output logic               s_bus_ctrl,
	output logic               psw_update,
	output logic [5:0]         alu_op,
	output logic [RNUM_W-1:0]  alu_rnum_dst,
	output logic [RNUM_W-1:0]  alu_rnum_src,
	output logic [RNUM_W-1:0]  dbus_rnum_dst,
	output logic [RNUM_W-1:0]  dbus_rnum_src,
	output bus_src_e           data_src,
	output bus_dst_e           data_dst,
	output logic               data_wb,
	output logic               data_wr,
	output logic               decode_strobe,
	output logic               exec_strobe
);

	cycle_e             state;
	cycle_e             state_nxt;
	logic [6:0]         op_base;
	logic [6:0]         op_ofs;
	logic               mar_load_n;
	logic               id_enable_n;
	logic               alu_enable_n;
	logic               sxt_enable_n;
	logic               s_bus_ctrl_n;
	logic               psw_update_n;
	logic               data_wr_n;
	logic               decode_strobe_n;
	logic               exec_strobe_n;
	logic [5:0]         alu_op_n;
	logic [RNUM_W-1:0]  alu_rnum_dst_n;
	logic [RNUM_W-1:0]  alu_rnum_src_n;
	logic [RNUM_W-1:0]  dbus_rnum_dst_n;
	logic [RNUM_W-1:0]  dbus_rnum_src_n;
	bus_src_e           data_src_n;
	bus_dst_e           data_dst_n;
	logic               data_wb_n;

	// ALU op is twice the group offset plus the W/B bit
	assign op_base = (instr_class == CLS_SHIFT) ? SHIFT_OP_BASE : ALU_OP_BASE;
	assign op_ofs  = op - op_base;

	always_comb
	begin
		case (state)
			FETCH:   state_nxt = PC_INC;
			PC_INC:  state_nxt = IR_LOAD;
			IR_LOAD: state_nxt = DECODE;
			DECODE:  state_nxt = EXECUTE;
			default: state_nxt = FETCH;	// Every kept op ends in one execute cycle
		endcase
	end

	always_comb
	begin
		mar_load_n      = 1'b0;
		id_enable_n     = 1'b0;
		alu_enable_n    = 1'b0;
		sxt_enable_n    = 1'b0;
		s_bus_ctrl_n    = 1'b0;	// S-bus from register file
		psw_update_n    = 1'b0;
		data_wr_n       = 1'b0;
		decode_strobe_n = 1'b0;
		exec_strobe_n   = 1'b0;
		alu_op_n        = 6'd0;	// ADD
		alu_rnum_dst_n  = REG_PC;
		alu_rnum_src_n  = REG_CONST2;
		dbus_rnum_dst_n = REG_PC;
		dbus_rnum_src_n = REG_PC;
		data_src_n      = MDR;
		data_dst_n      = MDR_DST;
		data_wb_n       = 1'b0;	// Word transfer
		if (!halted)	// Everything stays low at the breakpoint
		begin
			case (state)
				FETCH:
					mar_load_n = 1'b1;	// PC to MAR, memory read starts
				PC_INC:
				begin
					alu_enable_n = 1'b1;	// PC + 2 with default regs
					data_src_n   = ALU;
					data_dst_n   = REG_DST;
					data_wr_n    = 1'b1;
				end
				IR_LOAD:
				begin
					data_src_n = MDR;	// Fetched word into IR
					data_dst_n = IR_DST;
					data_wr_n  = 1'b1;
				end
				DECODE:
				begin
					decode_strobe_n = 1'b1;	// Skipped ops still use a CEX count
					id_enable_n     = instr_run;
				end
				default:	// EXECUTE
				begin
					exec_strobe_n = instr_run;
					if (instr_run)
					begin
						case (instr_class)
							CLS_ALU, CLS_SHIFT:
							begin
								alu_enable_n    = 1'b1;
								psw_update_n    = 1'b1;	// Flags from ALU
								alu_op_n        = {op_ofs[4:0], wb};
								alu_rnum_dst_n  = {2'b00, dst};
								alu_rnum_src_n  = {1'b0, rc, srccon};	// RC picks constants 8 to 15
								dbus_rnum_dst_n = {2'b00, dst};	// Result back to dst
								data_src_n      = ALU;
								data_dst_n      = REG_DST;
								data_wb_n       = wb;
								data_wr_n       = 1'b1;
							end
							CLS_BRANCH:
							begin
								if (branch_taken)
								begin
									sxt_enable_n = 1'b1;	// Offset from IR
									s_bus_ctrl_n = 1'b1;	// S-bus from sign extender
									alu_enable_n = 1'b1;	// PC + offset
									data_src_n   = ALU;
									data_dst_n   = REG_DST;
									data_wr_n    = 1'b1;
								end
							end
							CLS_MOV:
							begin
								dbus_rnum_dst_n = {2'b00, dst};
								dbus_rnum_src_n = {2'b00, srccon};
								data_src_n      = REGFILE;
								data_dst_n      = REG_DST;
								data_wb_n       = wb;
								data_wr_n       = 1'b1;
							end
							default:
								data_wr_n = 1'b0;	// SETCC, CLRCC, CEX handled in PSW unit
						endcase
					end
				end
			endcase
		end
	end

	// Controls, one clock behind the state
	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			state         <= FETCH;
			mar_load      <= 1'b0;
			id_enable     <= 1'b0;
			alu_enable    <= 1'b0;
			sxt_enable    <= 1'b0;
			s_bus_ctrl    <= 1'b0;
			psw_update    <= 1'b0;
			data_wr       <= 1'b0;
			decode_strobe <= 1'b0;
			exec_strobe   <= 1'b0;
		end
		else
		begin
			if (!halted)
				state <= state_nxt;	// Hold the cycle at breakpoint
			mar_load      <= mar_load_n;
			id_enable     <= id_enable_n;
			alu_enable    <= alu_enable_n;
			sxt_enable    <= sxt_enable_n;
			s_bus_ctrl    <= s_bus_ctrl_n;
			psw_update    <= psw_update_n;
			data_wr       <= data_wr_n;
			decode_strobe <= decode_strobe_n;
			exec_strobe   <= exec_strobe_n;
		end
	end

	// Register numbers and selects, qualified by the enables
	always_ff @(posedge clock)
	begin
		alu_op        <= alu_op_n;
		alu_rnum_dst  <= alu_rnum_dst_n;
		alu_rnum_src  <= alu_rnum_src_n;
		dbus_rnum_dst <= dbus_rnum_dst_n;
		dbus_rnum_src <= dbus_rnum_src_n;
		data_src      <= data_src_n;
		data_dst      <= data_dst_n;
		data_wb       <= data_wb_n;
	end

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// Opcodes kept from the full ISA, original numbering
	typedef enum logic [6:0]
	{
		BEQ   = 7'd1,	// Branch group, 1 to 8
		BNE   = 7'd2,
		BC    = 7'd3,
		BNC   = 7'd4,
		BN    = 7'd5,
		BGE   = 7'd6,
		BLT   = 7'd7,
		BRA   = 7'd8,
		ADD   = 7'd9,	// Two-operand ALU group, 9 to 20
		ADDC  = 7'd10,
		SUB   = 7'd11,
		SUBC  = 7'd12,
		DADD  = 7'd13,
		CMP   = 7'd14,
		XOR   = 7'd15,
		AND   = 7'd16,
		OR    = 7'd17,
		BIT   = 7'd18,
		BIC   = 7'd19,
		BIS   = 7'd20,
		MOV   = 7'd21,	// Register to register
		SRA   = 7'd23,	// Shifts share the ALU
		RRC   = 7'd24,
		SETCC = 7'd29,	// PSW flag set
		CLRCC = 7'd30,	// PSW flag clear
		CEX   = 7'd31	// Conditional execution
	} opcode_e;

	// Condition codes for branches and CEX
	typedef enum logic [3:0]
	{
		EQ = 4'd0,	// Z set
		NE = 4'd1,	// Z clear
		CS = 4'd2,	// C set
		CC = 4'd3,	// C clear
		MI = 4'd4,	// N set
		PL = 4'd5,	// N clear
		VS = 4'd6,	// V set
		VC = 4'd7,	// V clear
		HI = 4'd8,	// C set and Z clear
		LS = 4'd9,	// C clear or Z set
		GE = 4'd10,	// N equals V
		LT = 4'd11,	// N differs from V
		GT = 4'd12,	// Z clear and N equals V
		LE = 4'd13,	// Z set or N differs from V
		AL = 4'd14	// Always; 15 never passes
	} cond_e;

	// PSW flag positions
	localparam int PSW_C   = 0;
	localparam int PSW_Z   = 1;
	localparam int PSW_N   = 2;
	localparam int PSW_SLP = 3;	// Sleep, set while at the breakpoint
	localparam int PSW_V   = 4;

	localparam logic [6:0] ALU_OP_BASE   = 7'd9;	// ADD maps to ALU op 0
	localparam logic [6:0] SHIFT_OP_BASE = 7'd11;	// SRA and RRC land after BIS

endpackage

`default_nettype wire

// File: rtl/op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_decode import isa_pkg::*, ctrl_pkg::*;
(
	input  wire logic [6:0]        op,
	input  wire logic [3:0]        cond,
	input  wire logic [DATA_W-1:0] psw,
	output instr_class_e           instr_class,
	output logic                   branch_taken,
	output logic                   cex_true
);

	opcode_e opc;
	cond_e   branch_cond;

	// Flag rules shared by branches and CEX
	function automatic logic cond_true(input cond_e c, input logic [DATA_W-1:0] p);
		logic c_f;
		logic z_f;
		logic n_f;
		logic v_f;
		c_f = p[PSW_C];
		z_f = p[PSW_Z];
		n_f = p[PSW_N];
		v_f = p[PSW_V];
		case (c)
			EQ:      cond_true = z_f;
			NE:      cond_true = !z_f;
			CS:      cond_true = c_f;
			CC:      cond_true = !c_f;
			MI:      cond_true = n_f;
			PL:      cond_true = !n_f;
			VS:      cond_true = v_f;
			VC:      cond_true = !v_f;
			HI:      cond_true = c_f && !z_f;
			LS:      cond_true = !c_f || z_f;
			GE:      cond_true = (n_f == v_f);
			LT:      cond_true = (n_f != v_f);
			GT:      cond_true = !z_f && (n_f == v_f);
			LE:      cond_true = z_f || (n_f != v_f);
			AL:      cond_true = 1'b1;
			default: cond_true = 1'b0;	// Code 15
		endcase
	endfunction

	assign opc = opcode_e'(op);	// Raw IR field to opcode

	always_comb
	begin
		case (opc)
			BEQ, BNE, BC, BNC, BN, BGE, BLT, BRA:	instr_class = CLS_BRANCH;
			ADD, ADDC, SUB, SUBC, DADD, CMP,
			XOR, AND, OR, BIT, BIC, BIS:			instr_class = CLS_ALU;
			SRA, RRC:								instr_class = CLS_SHIFT;
			MOV:									instr_class = CLS_MOV;
			SETCC:									instr_class = CLS_SETCC;
			CLRCC:									instr_class = CLS_CLRCC;
			CEX:									instr_class = CLS_CEX;
			default:								instr_class = CLS_NONE;
		endcase
	end

	// Branch opcode to condition code
	always_comb
	begin
		case (opc)
			BEQ:     branch_cond = EQ;
			BNE:     branch_cond = NE;
			BC:      branch_cond = CS;
			BNC:     branch_cond = CC;
			BN:      branch_cond = MI;
			BGE:     branch_cond = GE;
			BLT:     branch_cond = LT;
			default: branch_cond = AL;	// BRA; others masked below
		endcase
	end

	assign branch_taken = (instr_class == CLS_BRANCH) && cond_true(branch_cond, psw);
	assign cex_true     = cond_true(cond_e'(cond), psw);	// CEX uses its own field

endmodule

`default_nettype wire

// File: rtl/psw_cex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module psw_cex_unit import isa_pkg::*, ctrl_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              cpucycle_rst,
	input  wire logic [DATA_W-1:0] psw_in,
	input  wire logic [DATA_W-1:0] pc,
	input  wire logic [DATA_W-1:0] brkpnt,
	input  wire instr_class_e      instr_class,
	input  wire logic [4:0]        pswb,
	input  wire logic              cex_true,
	input  wire logic [2:0]        true_cnt,
	input  wire logic [2:0]        false_cnt,
	input  wire logic              decode_strobe,
	input  wire logic              exec_strobe,
	output logic [DATA_W-1:0]      psw_out,
	output logic                   instr_run,
	output logic                   halted
);

	logic [DATA_W-1:0] psw_nxt;
	logic              cex_active;	// CEX window open
	logic              cex_result;	// Condition at CEX time
	logic [2:0]        cex_tcnt;	// True-group ops left
	logic [2:0]        cex_fcnt;	// False-group ops left
	logic              cex_last;	// One op left in the window

	assign halted = (pc == brkpnt);

	// True group is consumed first, then the false group
	always_comb
	begin
		if (!cex_active)
			instr_run = 1'b1;
		else if (cex_tcnt != 3'd0)
			instr_run = cex_result;
		else if (cex_fcnt != 3'd0)
			instr_run = !cex_result;
		else
			instr_run = 1'b1;	// Empty window, closes on next decode
	end

	assign cex_last = ((cex_tcnt == 3'd0) && (cex_fcnt <= 3'd1)) ||
		((cex_tcnt == 3'd1) && (cex_fcnt == 3'd0));

	// PSW follows the ALU flags; strobe comes the cycle after EXECUTE
	always_comb
	begin
		psw_nxt          = psw_in;
		psw_nxt[PSW_SLP] = halted;	// Sleep while at breakpoint
		if (exec_strobe && (instr_class == CLS_SETCC))
			psw_nxt[PSW_V:PSW_C] = psw_in[PSW_V:PSW_C] | pswb;
		else if (exec_strobe && (instr_class == CLS_CLRCC))
			psw_nxt[PSW_V:PSW_C] = psw_in[PSW_V:PSW_C] & ~pswb;
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			psw_out    <= PSW_RESET;
			cex_active <= 1'b0;
			cex_result <= 1'b0;
			cex_tcnt   <= 3'd0;
			cex_fcnt   <= 3'd0;
		end
		else
		begin
			psw_out <= psw_nxt;
			if (exec_strobe && (instr_class == CLS_CEX))
			begin
				cex_active <= 1'b1;	// Window covers the following ops
				cex_result <= cex_true;
				cex_tcnt   <= true_cnt;
				cex_fcnt   <= false_cnt;
			end
			else if (decode_strobe && cex_active)
			begin
				if (cex_tcnt != 3'd0)
					cex_tcnt <= cex_tcnt - 3'd1;
				else if (cex_fcnt != 3'd0)
					cex_fcnt <= cex_fcnt - 3'd1;
				if (cex_last)
					cex_active <= 1'b0;	// Both counts used up
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/control_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit_asserts import isa_pkg::*, ctrl_pkg::*;
(
	input wire logic              clock,
	input wire logic              cpucycle_rst,
	input wire logic [6:0]        op,
	input wire logic [3:0]        cond,
	input wire logic [2:0]        true_cnt,
	input wire logic [2:0]        false_cnt,
	input wire logic [4:0]        pswb,
	input wire logic [2:0]        dst,
	input wire logic [2:0]        srccon,
	input wire logic              wb,
	input wire logic              rc,
	input wire logic [15:0]       pc,
	input wire logic [15:0]       brkpnt,
	input wire logic [15:0]       psw_in,
	input wire logic              mar_load,
	input wire logic              id_enable,
	input wire logic              alu_enable,
	input wire logic              sxt_enable,
	input wire logic              s_bus_ctrl,
	input wire logic              psw_update,
	input wire logic [5:0]        alu_op,
	input wire logic [RNUM_W-1:0] alu_rnum_dst,
	input wire logic [RNUM_W-1:0] alu_rnum_src,
	input wire logic [RNUM_W-1:0] dbus_rnum_dst,
	input wire logic [RNUM_W-1:0] dbus_rnum_src,
	input wire logic [1:0]        data_src,
	input wire logic [1:0]        data_dst,
	input wire logic              data_wb,
	input wire logic              data_wr,
	input wire logic [15:0]       psw_out
);

	int                fail_count = 0;	// Failed checks so far
	logic              at_brk;
	logic              ir_load;	// IR_LOAD controls on the bus
	logic              is_alu;
	logic              is_shift;
	logic              is_branch;
	logic              is_ccr;	// SETCC or CLRCC
	logic [6:0]        op_ofs;
	logic [5:0]        exp_alu_op;
	logic [RNUM_W-1:0] exp_src;
	logic [4:0]        exp_ccr;
	logic              exp_taken;
	logic              exp_run;	// Instruction not skipped by CEX
	logic              cex_on;
	logic              cex_res;
	logic [2:0]        t_left;
	logic [2:0]        f_left;
	logic [1:0]        taken_q;
	logic [4:0]        ccr_q;
	logic              run_q;
	logic [10:0]       psw_hi_q;
	logic [4:0]        psw_lo_q;
	logic [1:0]        ccr_due;

	// Condition table on C, Z, N and V
	function automatic logic cond_holds(input logic [3:0] c, input logic [15:0] p);
		case (c)
			EQ:      return p[PSW_Z];
			NE:      return !p[PSW_Z];
			CS:      return p[PSW_C];
			CC:      return !p[PSW_C];
			MI:      return p[PSW_N];
			PL:      return !p[PSW_N];
			VS:      return p[PSW_V];
			VC:      return !p[PSW_V];
			HI:      return p[PSW_C] && !p[PSW_Z];
			LS:      return !p[PSW_C] || p[PSW_Z];
			GE:      return p[PSW_N] == p[PSW_V];
			LT:      return p[PSW_N] != p[PSW_V];
			GT:      return !p[PSW_Z] && (p[PSW_N] == p[PSW_V]);
			LE:      return p[PSW_Z] || (p[PSW_N] != p[PSW_V]);
			AL:      return 1'b1;
			default: return 1'b0;	// Code 15 never passes
		endcase
	endfunction

	function automatic logic branch_holds(input logic [6:0] o, input logic [15:0] p);
		case (o)
			BEQ:     return cond_holds(EQ, p);
			BNE:     return cond_holds(NE, p);
			BC:      return cond_holds(CS, p);
			BNC:     return cond_holds(CC, p);
			BN:      return cond_holds(MI, p);
			BGE:     return cond_holds(GE, p);
			BLT:     return cond_holds(LT, p);
			BRA:     return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	assign at_brk     = (pc == brkpnt);
	assign ir_load    = data_wr && (data_dst == IR_DST);
	assign is_alu     = (op >= ADD) && (op <= BIS);
	assign is_shift   = (op == SRA) || (op == RRC);
	assign is_branch  = (op >= BEQ) && (op <= BRA);
	assign is_ccr     = (op == SETCC) || (op == CLRCC);
	assign op_ofs     = op - (is_shift ? SHIFT_OP_BASE : ALU_OP_BASE);
	assign exp_alu_op = (op_ofs[5:0] << 1) + {5'd0, wb};	// Twice the offset plus W/B
	assign exp_src    = {2'b00, srccon} + (rc ? 5'd8 : 5'd0);	// Constants 8 to 15
	assign exp_ccr    = (op == SETCC) ? (psw_in[4:0] | pswb) : (psw_in[4:0] & ~pswb);
	assign exp_taken  = branch_holds(op, psw_in);

	// True group first, then false group
	assign exp_run = !cex_on ||
		((t_left != 3'd0) ? cex_res : ((f_left != 3'd0) ? !cex_res : 1'b1));

	// Skip window, stepped at each decode
	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			cex_on  <= 1'b0;
			cex_res <= 1'b0;
			t_left  <= 3'd0;
			f_left  <= 3'd0;
		end
		else if (ir_load && !at_brk)
		begin
			if (exp_run && (op == CEX))
			begin
				cex_on  <= 1'b1;	// New window replaces the old one
				cex_res <= cond_holds(cond, psw_in);
				t_left  <= true_cnt;
				f_left  <= false_cnt;
			end
			else if (cex_on)
			begin
				if (t_left != 3'd0)
					t_left <= t_left - 3'd1;
				else if (f_left != 3'd0)
					f_left <= f_left - 3'd1;
				if (({1'b0, t_left} + {1'b0, f_left}) <= 4'd1)
					cex_on <= 1'b0;	// Last count used
			end
		end
	end

	// Expected values lined up with the checked cycle
	always_ff @(posedge clock)
	begin
		taken_q  <= {taken_q[0], exp_taken};
		ccr_q    <= exp_ccr;
		run_q    <= exp_run;
		psw_hi_q <= psw_in[15:5];
		psw_lo_q <= {psw_in[PSW_V], at_brk, psw_in[PSW_N:PSW_C]};	// SLP from the breakpoint
		ccr_due  <= {ccr_due[0], id_enable && is_ccr};	// Flags written two clocks on
	end

	reset_idle: assert property (@(posedge clock)
		cpucycle_rst |=> (psw_out == PSW_RESET) && !mar_load && !id_enable && !alu_enable &&
			!sxt_enable && !psw_update && !data_wr)
	else
	begin
		fail_count++;
		$error("[ERROR] after reset psw_out %h mar_load %h alu_enable %h data_wr %h",
			$sampled(psw_out), $sampled(mar_load), $sampled(alu_enable), $sampled(data_wr));
	end

	pc_inc_ctrl: assert property (@(posedge clock) disable iff (cpucycle_rst)
		mar_load && !at_brk |=> alu_enable && (alu_rnum_dst == REG_PC) &&
			(alu_rnum_src == REG_CONST2))
	else
	begin
		fail_count++;
		$error("[ERROR] PC_INC alu_enable %h alu_rnum_dst %h alu_rnum_src %h",
			$sampled(alu_enable), $sampled(alu_rnum_dst), $sampled(alu_rnum_src));
	end

	ir_load_ctrl: assert property (@(posedge clock) disable iff (cpucycle_rst)
		mar_load && !at_brk ##1 !at_brk |=> ir_load && (data_src == MDR))
	else
	begin
		fail_count++;
		$error("[ERROR] IR_LOAD data_wr %h data_dst %h data_src %h",
			$sampled(data_wr), $sampled(data_dst), $sampled(data_src));
	end

	instr_period: assert property (@(posedge clock) disable iff (cpucycle_rst)
		mar_load && !at_brk ##1 !at_brk [*4] |=> mar_load)
	else
	begin
		fail_count++;
		$error("[ERROR] mar_load %h five clocks after the last one, expected 1",
			$sampled(mar_load));
	end

	alu_exec: assert property (@(posedge clock) disable iff (cpucycle_rst)
		mar_load ##3 (id_enable && !at_brk && (is_alu || is_shift)) |=>
			alu_enable && psw_update && data_wr && (alu_op == exp_alu_op) &&
			(alu_rnum_dst == {2'b00, dst}) && (alu_rnum_src == exp_src) &&
			(dbus_rnum_dst == {2'b00, dst}) && (data_src == ALU) &&
			(data_dst == REG_DST) && (data_wb == wb))
	else
	begin
		fail_count++;
		$error(
			"[ERROR] op %h alu_op %h exp %h alu_rnum_src %h exp %h alu_rnum_dst %h data_wb %h",
			$sampled(op), $sampled(alu_op), $sampled(exp_alu_op), $sampled(alu_rnum_src),
			$sampled(exp_src), $sampled(alu_rnum_dst), $sampled(data_wb));
	end

	branch_exec: assert property (@(posedge clock) disable iff (cpucycle_rst)
		mar_load ##3 (id_enable && !at_brk && is_branch) |=> (alu_enable == taken_q[1]) &&
			(sxt_enable == taken_q[1]) && (s_bus_ctrl == taken_q[1]))
	else
	begin
		fail_count++;
		$error("[ERROR] op %h alu_enable %h sxt_enable %h s_bus_ctrl %h exp %h",
			$sampled(op), $sampled(alu_enable), $sampled(sxt_enable), $sampled(s_bus_ctrl),
			$sampled(taken_q[1]));
	end

	mov_exec: assert property (@(posedge clock) disable iff (cpucycle_rst)
		mar_load ##3 (id_enable && !at_brk && (op == MOV)) |=> data_wr && !alu_enable &&
			(data_src == REGFILE) && (dbus_rnum_src == {2'b00, srccon}) &&
			(dbus_rnum_dst == {2'b00, dst}) && (data_dst == REG_DST) && (data_wb == wb))
	else
	begin
		fail_count++;
		$error("[ERROR] MOV data_src %h dbus_rnum_src %h dbus_rnum_dst %h data_wb %h",
			$sampled(data_src), $sampled(dbus_rnum_src), $sampled(dbus_rnum_dst),
			$sampled(data_wb));
	end

	ccr_update: assert property (@(posedge clock) disable iff (cpucycle_rst)
		mar_load ##3 (id_enable && !at_brk && is_ccr) ##1 1'b1 |=> psw_out[4:0] == ccr_q)
	else
	begin
		fail_count++;
		$error("[ERROR] psw_out[4:0] %h exp %h", $sampled(psw_out[4:0]), $sampled(ccr_q));
	end

	skip_rule: assert property (@(posedge clock) disable iff (cpucycle_rst)
		ir_load && !at_brk |=> id_enable == run_q)
	else
	begin
		fail_count++;
		$error("[ERROR] id_enable %h exp %h", $sampled(id_enable), $sampled(run_q));
	end

	halt_idle: assert property (@(posedge clock) disable iff (cpucycle_rst)
		at_brk |=> !mar_load && !id_enable && !alu_enable && !data_wr && psw_out[PSW_SLP])
	else
	begin
		fail_count++;
		$error("[ERROR] at breakpoint mar_load %h alu_enable %h psw_out %h",
			$sampled(mar_load), $sampled(alu_enable), $sampled(psw_out));
	end

	psw_follow: assert property (@(posedge clock) disable iff (cpucycle_rst)
		1'b1 |=> (psw_out[15:5] == psw_hi_q) && (ccr_due[1] || (psw_out[4:0] == psw_lo_q)))
	else
	begin
		fail_count++;
		$error("[ERROR] psw_out %h exp %h", $sampled(psw_out), $sampled({psw_hi_q, psw_lo_q}));
	end

endmodule

bind control_unit control_unit_asserts i_control_unit_asserts (.*);

`default_nettype wire

// File: testbench/tb_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_control_unit
	import isa_pkg::*;
();

	logic        clock;
	logic        cpucycle_rst;
	logic [6:0]  op;
	logic [3:0]  cond;
	logic [2:0]  true_cnt;
	logic [2:0]  false_cnt;
	logic [4:0]  pswb;
	logic [2:0]  dst;
	logic [2:0]  srccon;
	logic        wb;
	logic        rc;
	logic [15:0] pc;
	logic [15:0] brkpnt;
	logic [15:0] psw_in;
	logic        mar_load;
	logic        id_enable;
	logic        alu_enable;
	logic        sxt_enable;
	logic        s_bus_ctrl;
	logic        psw_update;
	logic [5:0]  alu_op;
	logic [4:0]  alu_rnum_dst;
	logic [4:0]  alu_rnum_src;
	logic [4:0]  dbus_rnum_dst;
	logic [4:0]  dbus_rnum_src;
	logic [1:0]  data_src;
	logic [1:0]  data_dst;
	logic        data_wb;
	logic        data_wr;
	logic [15:0] psw_out;

	logic [31:0] rng;	// Xorshift state
	int          timeouts;
	int          assert_fails;
	int          i;

	control_unit i_control_unit (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#10 clock = ~clock;	// 20 ns period
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Mix of ALU, shift, branch, PSW and MOV ops
	function automatic logic [6:0] op_from_rand(input logic [31:0] r);
		logic [6:0] o;
		case (r[2:0])
			3'd0, 3'd1, 3'd2: o = ADD + (r[7:4] % 12);
			3'd3:             o = r[8] ? RRC : SRA;
			3'd4, 3'd5:       o = BEQ + r[6:4];	// All eight branches
			3'd6:             o = r[9] ? CLRCC : SETCC;
			default:          o = MOV;
		endcase
		return o;
	endfunction

	// Returns on the falling edge that sees mar_load
	task automatic wait_instr_start();
		int n;
		n = 0;
		@(negedge clock);
		while (!mar_load && (n < 40))
		begin
			@(negedge clock);
			n++;
		end
		if (!mar_load)
		begin
			timeouts++;
			$display("Timeout: no instruction start within %0d clocks", n);
		end
	endtask

	// Fields hold until the next instruction start
	task automatic issue_instr(input logic [6:0] o, input logic [3:0] c,
		input logic [2:0] tc, input logic [2:0] fc);
		wait_instr_start();
		rng       = xorshift32(rng);
		op        = o;
		cond      = c;
		true_cnt  = tc;
		false_cnt = fc;
		dst       = rng[2:0];
		srccon    = rng[5:3];
		wb        = rng[6];
		rc        = rng[7];
		pswb      = rng[12:8];
		psw_in    = rng[31:16];	// Random flags for branches and CEX
	endtask

	task automatic issue_random();
		rng = xorshift32(rng);
		issue_instr(op_from_rand(rng), rng[15:12], rng[18:16], rng[21:19]);
	endtask

	// CEX followed by enough ops to close its window
	task automatic run_cex_window(input logic [3:0] c, input logic [2:0] tc,
		input logic [2:0] fc);
		int k;
		issue_instr(CEX, c, tc, fc);
		for (k = 0; k <= tc + fc; k++)
			issue_random();
	endtask

	initial
	begin
		rng          = 32'h4eda4c02;
		timeouts     = 0;
		cpucycle_rst = 1'b1;
		op           = MOV;
		cond         = 4'd14;
		true_cnt     = 3'd0;
		false_cnt    = 3'd0;
		pswb         = 5'd0;
		dst          = 3'd0;
		srccon       = 3'd0;
		wb           = 1'b0;
		rc           = 1'b0;
		pc           = 16'h0100;
		brkpnt       = 16'hfffe;	// Out of reach until the halt test
		psw_in       = 16'h0000;
		repeat (3) @(posedge clock);
		@(negedge clock);
		cpucycle_rst = 1'b0;

		for (i = 0; i < 60; i++)
			issue_random();

		run_cex_window(4'd14, 3'd2, 3'd1);	// AL, true group runs
		run_cex_window(4'd15, 3'd1, 3'd2);	// Never true, false group runs
		run_cex_window(4'd0, 3'd0, 3'd3);	// EQ on random Z
		run_cex_window(4'd1, 3'd3, 3'd0);
		run_cex_window(4'd10, 3'd2, 3'd2);
		run_cex_window(4'd14, 3'd0, 3'd0);	// Empty window

		// Breakpoint hit mid-instruction, then released
		issue_instr(MOV, 4'd14, 3'd0, 3'd0);
		pc = 16'hfffe;
		repeat (12) @(negedge clock);
		pc = 16'h0104;
		for (i = 0; i < 6; i++)
			issue_random();

		issue_instr(MOV, 4'd14, 3'd0, 3'd0);
		issue_instr(MOV, 4'd14, 3'd0, 3'd0);
		wait_instr_start();	// Last checks settle

		assert_fails = i_control_unit.i_control_unit_asserts.fail_count;
		$display("Assertion failures: %0d, timeouts: %0d", assert_fails, timeouts);
		if ((assert_fails + timeouts) == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
